// ==== common/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Major opcodes, RV32I base
`define RV_OP_LUI     7'b011_0111
`define RV_OP_AUIPC   7'b001_0111
`define RV_OP_JAL     7'b110_1111
`define RV_OP_JALR    7'b110_0111
`define RV_OP_BRANCH  7'b110_0011
`define RV_OP_LOAD    7'b000_0011
`define RV_OP_STORE   7'b010_0011
`define RV_OP_OP      7'b011_0011
`define RV_OP_IMM     7'b001_0011

`define RV_XLEN       32
`define RV_NUM_REGS   32

`define RV_RESET_PC   32'h0000_0000

`endif

// ==== common/common.sv ====
package common;

    `include "rv_consts.svh"

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_id_t;

    // Same bit order as the 32-bit encoding
    typedef struct packed {
        logic [6:0] funct7;
        reg_id_t    rs2;
        reg_id_t    rs1;
        logic [2:0] funct3;
        reg_id_t    rd;
        logic [6:0] opcode;
    } instruction_type;

    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } encoding_e;

    typedef enum logic [4:0] {
        ALU_ADD,    // Must stay zero, an empty control word adds
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_MUL,
        ALU_MULH,
        ALU_DIV,
        ALU_DIVU,
        ALU_REM,
        ALU_REMU,
        ALU_PASS
    } alu_op_e;

    typedef struct packed {
        encoding_e  encoding;
        logic       reg_write;
        logic       alu_src;     // Operand b from immediate
        logic       mem_read;
        logic       mem_write;
        logic       mem_to_reg;
        logic       is_branch;
        logic       is_jump;
        logic       is_jumpr;
        logic       is_auipc;
        logic       is_lui;
        alu_op_e    alu_op;
        logic [2:0] funct3;
        reg_id_t    rs1_id;
        reg_id_t    rs2_id;
    } control_type;

    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic [3:0] be;
        logic       re;
        logic       we;
    } mem_req_t;

    typedef struct packed {
        logic    we;
        reg_id_t rd;
        word_t   data;
    } wb_t;

endpackage

// ==== hw/control_unit.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

module control_unit
    import common::*;
(
    input  instruction_type instruction,
    output control_type     control
);

    logic known;

    always_comb begin
        control = '0;
        known   = 1'b1;

        case (instruction.opcode)
            `RV_OP_OP: begin
                control.encoding  = R_TYPE;
                control.reg_write = 1'b1;
            end
            `RV_OP_IMM: begin
                control.encoding  = I_TYPE;
                control.reg_write = 1'b1;
                control.alu_src   = 1'b1;
            end
            `RV_OP_LOAD: begin
                control.encoding   = I_TYPE;
                control.reg_write  = 1'b1;
                control.alu_src    = 1'b1;
                control.mem_read   = 1'b1;
                control.mem_to_reg = 1'b1;
            end
            `RV_OP_STORE: begin
                control.encoding  = S_TYPE;
                control.alu_src   = 1'b1;
                control.mem_write = 1'b1;
            end
            `RV_OP_BRANCH: begin
                control.encoding  = B_TYPE;
                control.is_branch = 1'b1;
            end
            `RV_OP_JAL: begin
                control.encoding  = J_TYPE;
                control.reg_write = 1'b1;
                control.is_jump   = 1'b1;
            end
            `RV_OP_JALR: begin
                control.encoding  = I_TYPE;
                control.reg_write = 1'b1;
                control.is_jumpr  = 1'b1;
            end
            `RV_OP_AUIPC: begin
                control.encoding  = U_TYPE;
                control.reg_write = 1'b1;
                control.alu_src   = 1'b1;
                control.is_auipc  = 1'b1;
            end
            `RV_OP_LUI: begin
                control.encoding  = U_TYPE;
                control.reg_write = 1'b1;
                control.alu_src   = 1'b1;
                control.is_lui    = 1'b1;
            end
            default: known = 1'b0;    // Unknown opcode stays all zero
        endcase

        if (known) begin
            control.funct3 = instruction.funct3;
            control.rs1_id = instruction.rs1;
            control.rs2_id = instruction.rs2;
        end

        case (instruction.opcode)
            `RV_OP_OP: begin
                case ({instruction.funct7, instruction.funct3})
                    10'b0100000_000: control.alu_op = ALU_SUB;
                    10'b0000000_001: control.alu_op = ALU_SLL;
                    10'b0000000_010: control.alu_op = ALU_SLT;
                    10'b0000000_011: control.alu_op = ALU_SLTU;
                    10'b0000000_100: control.alu_op = ALU_XOR;
                    10'b0000000_101: control.alu_op = ALU_SRL;
                    10'b0100000_101: control.alu_op = ALU_SRA;
                    10'b0000000_110: control.alu_op = ALU_OR;
                    10'b0000000_111: control.alu_op = ALU_AND;
                    10'b0000001_000: control.alu_op = ALU_MUL;
                    10'b0000001_001: control.alu_op = ALU_MULH;
                    10'b0000001_100: control.alu_op = ALU_DIV;
                    10'b0000001_101: control.alu_op = ALU_DIVU;
                    10'b0000001_110: control.alu_op = ALU_REM;
                    10'b0000001_111: control.alu_op = ALU_REMU;
                    default:         control.alu_op = ALU_ADD;
                endcase
            end
            `RV_OP_IMM: begin
                case (instruction.funct3)
                    3'b001:  control.alu_op = ALU_SLL;
                    3'b010:  control.alu_op = ALU_SLT;
                    3'b011:  control.alu_op = ALU_SLTU;
                    3'b100:  control.alu_op = ALU_XOR;
                    3'b101:  control.alu_op = instruction.funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  control.alu_op = ALU_OR;
                    3'b111:  control.alu_op = ALU_AND;
                    default: control.alu_op = ALU_ADD;
                endcase
            end
            `RV_OP_BRANCH: control.alu_op = ALU_SUB;
            `RV_OP_LUI:    control.alu_op = ALU_PASS;
            default:       control.alu_op = ALU_ADD;    // Address and AUIPC adds
        endcase
    end

    // pc_unit picks one target source only
    always_comb begin
        assert final ($onehot0({control.is_branch, control.is_jump, control.is_jumpr}))
            else $error("control_unit: more than one control-flow flag set");
    end

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

module imm_gen
    import common::*;
(
    input  instruction_type instruction,
    input  encoding_e       encoding,
    output word_t           imm
);

    word_t raw;
    logic  is_shift_imm;

    assign raw = instruction;

    // SLLI/SRLI/SRAI carry only a shamt, funct7 is not part of the value
    assign is_shift_imm = (instruction.opcode == `RV_OP_IMM) && (instruction.funct3[1:0] == 2'b01);

    always_comb begin
        case (encoding)
            I_TYPE:  imm = is_shift_imm ? {27'b0, raw[24:20]} : {{20{raw[31]}}, raw[31:20]};
            S_TYPE:  imm = {{20{raw[31]}}, raw[31:25], raw[11:7]};
            B_TYPE:  imm = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
            U_TYPE:  imm = {raw[31:12], 12'b0};
            J_TYPE:  imm = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
            default: imm = '0;    // R-type has none
        endcase
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

module reg_file
    import common::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  reg_id_t rs1_id,
    input  reg_id_t rs2_id,
    output word_t   rs1_data,
    output word_t   rs2_data,
    input  wb_t     wb
);

    word_t regs [`RV_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.rd != '0) begin    // x0 writes dropped
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = regs[rs1_id];
    assign rs2_data = regs[rs2_id];

    // x0 is cleared by reset and must never pick up a retired write
    assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_id == '0) |-> (rs1_data == '0))
        else $error("reg_file: x0 read back nonzero");

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu
    import common::*;
(
    input  control_type control,
    input  word_t       pc,
    input  word_t       rs1_data,
    input  word_t       rs2_data,
    input  word_t       imm,
    output word_t       result
);

    word_t             op_a;
    word_t             op_b;
    logic [4:0]        shamt;
    logic signed [63:0] product;
    word_t             quot_s;
    word_t             rem_s;
    logic              div_zero;
    logic              div_ovf;

    assign op_a  = control.is_auipc ? pc : rs1_data;
    assign op_b  = control.alu_src ? imm : rs2_data;
    assign shamt = op_b[4:0];

    assign product  = $signed(op_a) * $signed(op_b);
    assign quot_s   = $signed(op_a) / $signed(op_b);
    assign rem_s    = $signed(op_a) % $signed(op_b);
    assign div_zero = (op_b == '0);
    assign div_ovf  = (op_a == 32'h8000_0000) && (op_b == 32'hffff_ffff);    // -2^31 / -1

    always_comb begin
        case (control.alu_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = $signed(op_a) >>> shamt;
            ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {31'b0, op_a < op_b};
            ALU_MUL:  result = product[31:0];
            ALU_MULH: result = product[63:32];
            ALU_DIV:  result = div_zero ? '1 : div_ovf ? op_a : quot_s;
            ALU_DIVU: result = div_zero ? '1 : op_a / op_b;
            ALU_REM:  result = div_zero ? op_a : div_ovf ? '0 : rem_s;
            ALU_REMU: result = div_zero ? op_a : op_a % op_b;
            ALU_PASS: result = op_b;    // LUI
            default:  result = '0;
        endcase
    end

endmodule

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage
    import common::*;
(
    input  logic        rst_n,
    input  control_type control,
    input  reg_id_t     rd,
    input  word_t       pc,
    input  word_t       alu_result,
    input  word_t       rs2_data,
    input  word_t       mem_rdata,
    output mem_req_t    mem_req,
    output wb_t         wb
);

    logic [1:0] byte_off;
    word_t      lane;
    word_t      load_data;

    assign byte_off = alu_result[1:0];

    always_comb begin
        mem_req       = '0;
        mem_req.addr  = {alu_result[31:2], 2'b00};
        mem_req.re    = control.mem_read && rst_n;
        mem_req.we    = control.mem_write && rst_n;
        mem_req.wdata = rs2_data;
        if (control.mem_write) begin
            case (control.funct3[1:0])
                2'b00: begin    // SB
                    mem_req.be    = 4'b0001 << byte_off;
                    mem_req.wdata = rs2_data << {byte_off, 3'b000};
                end
                2'b01: begin    // SH
                    mem_req.be    = 4'b0011 << {byte_off[1], 1'b0};
                    mem_req.wdata = rs2_data << {byte_off[1], 4'b0000};
                end
                default: mem_req.be = 4'b1111;
            endcase
        end
    end

    assign lane = mem_rdata >> {byte_off, 3'b000};

    always_comb begin
        case (control.funct3)
            3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};
            3'b001:  load_data = {{16{lane[15]}}, lane[15:0]};
            3'b100:  load_data = {24'b0, lane[7:0]};
            3'b101:  load_data = {16'b0, lane[15:0]};
            default: load_data = mem_rdata;
        endcase
    end

    assign wb.we   = control.reg_write && rst_n;
    assign wb.rd   = rd;
    assign wb.data = control.mem_to_reg                    ? load_data :
                     (control.is_jump || control.is_jumpr) ? pc + 32'd4 :
                                                             alu_result;

    always_comb begin
        assert final (!(mem_req.re && mem_req.we))
            else $error("mem_stage: read and write requested together");
    end

endmodule

// ==== hw/pc_unit.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

module pc_unit
    import common::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  control_type control,
    input  word_t       rs1_data,
    input  word_t       rs2_data,
    input  word_t       imm,
    output word_t       pc
);

    logic  taken;
    word_t jalr_sum;
    word_t next_pc;

    always_comb begin
        case (control.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
            3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
            3'b110:  taken = rs1_data < rs2_data;
            3'b111:  taken = rs1_data >= rs2_data;
            default: taken = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_data + imm;

    always_comb begin
        if ((control.is_branch && taken) || control.is_jump) begin
            next_pc = pc + imm;
        end else if (control.is_jumpr) begin
            next_pc = {jalr_sum[31:1], 1'b0};
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // Targets come from decode, rs1 and imm over several instructions
    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc_unit: pc not word aligned");

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps

module rv_core
    import common::*;
(
    input  logic            clk,
    input  logic            rst_n,
    output word_t           instr_addr,
    input  instruction_type instr,
    output mem_req_t        mem_req,
    input  word_t           mem_rdata,
    output wb_t             retire
);

    control_type ctrl;
    word_t       imm;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       alu_result;
    word_t       pc;
    wb_t         wb;

    control_unit u_control_unit (
        .instruction (instr),
        .control     (ctrl)
    );

    imm_gen u_imm_gen (
        .instruction (instr),
        .encoding    (ctrl.encoding),
        .imm         (imm)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_id   (ctrl.rs1_id),
        .rs2_id   (ctrl.rs2_id),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    alu u_alu (
        .control  (ctrl),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .result   (alu_result)
    );

    mem_stage u_mem_stage (
        .rst_n      (rst_n),
        .control    (ctrl),
        .rd         (instr.rd),
        .pc         (pc),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .mem_rdata  (mem_rdata),
        .mem_req    (mem_req),
        .wb         (wb)
    );

    pc_unit u_pc_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .control  (ctrl),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .pc       (pc)
    );

    assign instr_addr = pc;
    assign retire     = wb;

endmodule

// ==== tests/tb_rv_core.sv ====
`timescale 1ns/1ps

`include "rv_consts.svh"

module tb_rv_core
    import common::*;
();

    logic            clk;
    logic            rst_n;
    word_t           instr_addr;
    instruction_type instr;
    mem_req_t        mem_req;
    word_t           mem_rdata;
    wb_t             retire;

    word_t prog [1024];
    word_t dmem [256];
    word_t m_mem [256];    // Model copy of data memory
    word_t m_regs [32];
    word_t m_pc;

    wb_t      exp_wb;
    mem_req_t exp_req;
    word_t    exp_next;

    int errors;
    int checks;
    int cycles;
    integer seed;

    rv_core uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_addr (instr_addr),
        .instr      (instr),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .retire     (retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        instr <= prog[instr_addr[11:2]];
    end

    // Same-cycle answer, follows the address of the current request
    assign mem_rdata = dmem[mem_req.addr[9:2]];

    always @(posedge clk) begin
        if (mem_req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_req.be[b]) begin
                    dmem[mem_req.addr[9:2]][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= 2000) begin
            $display("Timeout: the run did not finish within 2000 clock cycles");
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic word_t enc_r(logic [6:0] f7, logic [4:0] r2, logic [4:0] r1,
                                    logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {f7, r2, r1, f3, rd, op};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, logic [4:0] r1, logic [2:0] f3,
                                    logic [4:0] rd, logic [6:0] op);
        return {imm, r1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, logic [4:0] r2, logic [4:0] r1,
                                    logic [2:0] f3);
        return {imm[11:5], r2, r1, f3, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, logic [4:0] r2, logic [4:0] r1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], r2, r1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    function automatic word_t ref_alu(logic [6:0] f7, logic [2:0] f3, word_t a, word_t b);
        longint p;
        int     sa;
        int     sb;
        logic   ovf;
        sa  = a;
        sb  = b;
        p   = longint'(sa) * longint'(sb);
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        if (f7 == 7'b0000001) begin
            case (f3)
                3'd0: return p[31:0];
                3'd1: return p[63:32];
                3'd4: return (b == 0) ? 32'hffff_ffff : ovf ? a : word_t'(sa / sb);
                3'd5: return (b == 0) ? 32'hffff_ffff : a / b;
                3'd6: return (b == 0) ? a : ovf ? 32'd0 : word_t'(sa % sb);
                default: return (b == 0) ? a : a % b;
            endcase
        end
        case (f3)
            3'd0: return f7[5] ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return (sa < sb) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return f7[5] ? word_t'(sa >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA reference for one instruction, advances the model state
    task automatic model_step(input word_t ins);
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      immi;
        word_t      imms;
        word_t      ea;
        word_t      lane;
        logic       taken;
        f3   = ins[14:12];
        a    = m_regs[ins[19:15]];
        b    = m_regs[ins[24:20]];
        immi = {{20{ins[31]}}, ins[31:20]};
        imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        exp_wb   = '0;
        exp_req  = '0;
        exp_next = m_pc + 4;
        exp_wb.rd = ins[11:7];
        case (ins[6:0])
            `RV_OP_OP: begin
                exp_wb.we   = 1'b1;
                exp_wb.data = ref_alu(ins[31:25], f3, a, b);
            end
            `RV_OP_IMM: begin
                exp_wb.we   = 1'b1;
                exp_wb.data = ref_alu((f3 == 3'd5) ? {1'b0, ins[30], 5'b0} : 7'b0, f3, a, immi);
            end
            `RV_OP_LUI: begin
                exp_wb.we   = 1'b1;
                exp_wb.data = {ins[31:12], 12'b0};
            end
            `RV_OP_AUIPC: begin
                exp_wb.we   = 1'b1;
                exp_wb.data = m_pc + {ins[31:12], 12'b0};
            end
            `RV_OP_JAL: begin
                exp_wb.we   = 1'b1;
                exp_wb.data = m_pc + 4;
                exp_next    = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            `RV_OP_JALR: begin
                exp_wb.we   = 1'b1;
                exp_wb.data = m_pc + 4;
                exp_next    = (a + immi) & ~32'd1;
            end
            `RV_OP_BRANCH: begin
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = (int'(a) < int'(b));
                    3'd5:    taken = (int'(a) >= int'(b));
                    3'd6:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    exp_next = m_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            `RV_OP_LOAD: begin
                ea           = a + immi;
                exp_req.re   = 1'b1;
                exp_req.addr = {ea[31:2], 2'b00};
                lane         = m_mem[ea[9:2]] >> (8 * ea[1:0]);
                exp_wb.we    = 1'b1;
                case (f3)
                    3'd0:    exp_wb.data = {{24{lane[7]}}, lane[7:0]};
                    3'd1:    exp_wb.data = {{16{lane[15]}}, lane[15:0]};
                    3'd4:    exp_wb.data = {24'b0, lane[7:0]};
                    3'd5:    exp_wb.data = {16'b0, lane[15:0]};
                    default: exp_wb.data = m_mem[ea[9:2]];
                endcase
            end
            `RV_OP_STORE: begin
                ea           = a + imms;
                exp_req.we   = 1'b1;
                exp_req.addr = {ea[31:2], 2'b00};
                case (f3)
                    3'd0: begin
                        exp_req.be    = 4'b0001 << ea[1:0];
                        exp_req.wdata = b << (8 * ea[1:0]);
                    end
                    3'd1: begin
                        exp_req.be    = 4'b0011 << (2 * ea[1]);
                        exp_req.wdata = b << (16 * ea[1]);
                    end
                    default: begin
                        exp_req.be    = 4'b1111;
                        exp_req.wdata = b;
                    end
                endcase
                for (int i = 0; i < 4; i++) begin
                    if (exp_req.be[i]) begin
                        m_mem[ea[9:2]][8*i +: 8] = exp_req.wdata[8*i +: 8];
                    end
                end
            end
            default: ;    // Unknown opcode does nothing
        endcase
        if (exp_wb.we && exp_wb.rd != 0) begin
            m_regs[exp_wb.rd] = exp_wb.data;
        end
        m_pc = exp_next;
    endtask

    task automatic check_value(input string what, input word_t got, input word_t exp);
        checks++;
        assert (got === exp)
            else begin
                errors++;
                $display("ERR %0t: %s is %08h, expected %08h", $time, what, got, exp);
            end
    endtask

    // Called after a rising edge, before the falling edge that fetches
    task automatic run_instr(input word_t ins);
        word_t pc_now;
        pc_now = m_pc;
        prog[instr_addr[11:2]] = ins;
        model_step(ins);
        @(negedge clk);
        #1;
        check_value("instr_addr", instr_addr, pc_now);
        check_value("retire.we", retire.we, exp_wb.we);
        if (exp_wb.we) begin
            check_value("retire.rd", retire.rd, exp_wb.rd);
            check_value("retire.data", retire.data, exp_wb.data);
        end
        check_value("mem_req.re", mem_req.re, exp_req.re);
        check_value("mem_req.we", mem_req.we, exp_req.we);
        if (exp_req.re || exp_req.we) begin
            check_value("mem_req.addr", mem_req.addr, exp_req.addr);
        end
        if (exp_req.we) begin
            check_value("mem_req.be", mem_req.be, exp_req.be);
            check_value("mem_req.wdata", mem_req.wdata, exp_req.wdata);
        end
        @(posedge clk);
        #1;
        check_value("next instr_addr", instr_addr, exp_next);
    endtask

    task automatic load_reg(input logic [4:0] rd, input word_t val);
        word_t hi;
        hi = val + 32'h800;    // ADDI sign-extends the low part
        run_instr({hi[31:12], rd, `RV_OP_LUI});
        run_instr(enc_i(val[11:0], rd, 3'd0, rd, `RV_OP_IMM));
    endtask

    task automatic test_reset_nop();
        rst_n = 1'b0;
        repeat (8) @(negedge clk);
        #1;
        check_value("instr_addr in reset", instr_addr, `RV_RESET_PC);
        check_value("retire.we in reset", retire.we, 1'b0);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        m_pc = `RV_RESET_PC + 4;    // NOP at the reset PC
        check_value("instr_addr after NOP", instr_addr, m_pc);
        repeat (3) run_instr(32'h0000_0013);
    endtask

    task automatic test_int_alu();
        logic [2:0] f3;
        load_reg(1, $random(seed));
        load_reg(2, $random(seed));
        load_reg(3, 32'hffff_fffb);
        load_reg(4, 32'd7);
        for (int i = 0; i < 8; i++) begin
            f3 = i;
            run_instr(enc_r(7'b0, 2, 1, f3, 10, `RV_OP_OP));
            run_instr(enc_r(7'b0, 4, 3, f3, 11, `RV_OP_OP));
            if (f3 != 3'd1 && f3 != 3'd5) begin
                run_instr(enc_i($random(seed), 1, f3, 12, `RV_OP_IMM));
            end
        end
        run_instr(enc_r(7'b0100000, 2, 1, 3'd0, 13, `RV_OP_OP));     // SUB
        run_instr(enc_r(7'b0100000, 4, 3, 3'd5, 13, `RV_OP_OP));     // SRA
        run_instr(enc_i({7'b0, 5'd9}, 1, 3'd1, 14, `RV_OP_IMM));
        run_instr(enc_i({7'b0, 5'd9}, 3, 3'd5, 14, `RV_OP_IMM));
        run_instr(enc_i({7'b0100000, 5'd9}, 3, 3'd5, 14, `RV_OP_IMM));
        run_instr({20'habcde, 5'd15, `RV_OP_LUI});
        run_instr({20'h12345, 5'd16, `RV_OP_AUIPC});
    endtask

    task automatic test_mul_div();
        word_t pairs [10];
        logic [2:0] ops [6];
        pairs = '{$random(seed), $random(seed), 32'h0000_1234, 32'd0,
                  32'h8000_0000, 32'hffff_ffff, 32'hffff_ff9c, 32'd7,
                  32'd100, 32'hffff_fff9};
        ops   = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int p = 0; p < 10; p += 2) begin
            load_reg(5, pairs[p]);
            load_reg(6, pairs[p+1]);
            foreach (ops[k]) begin
                run_instr(enc_r(7'b0000001, 6, 5, ops[k], 17, `RV_OP_OP));
            end
        end
    endtask

    task automatic test_load_store();
        load_reg(10, 32'h100);
        load_reg(1, 32'h8765_43a1);
        run_instr(enc_s(12'd0, 1, 10, 3'd2));     // SW
        run_instr(enc_s(12'd6, 1, 10, 3'd1));     // SH upper half
        run_instr(enc_s(12'd4, 1, 10, 3'd1));
        run_instr(enc_s(12'd9, 1, 10, 3'd0));     // SB lane 1
        run_instr(enc_s(12'd11, 1, 10, 3'd0));
        for (int off = 0; off < 12; off++) begin
            run_instr(enc_i(off, 10, 3'd0, 18, `RV_OP_LOAD));
            run_instr(enc_i(off, 10, 3'd4, 18, `RV_OP_LOAD));
            if (off % 2 == 0) begin
                run_instr(enc_i(off, 10, 3'd1, 19, `RV_OP_LOAD));
                run_instr(enc_i(off, 10, 3'd5, 19, `RV_OP_LOAD));
            end
            if (off % 4 == 0) begin
                run_instr(enc_i(off, 10, 3'd2, 20, `RV_OP_LOAD));
            end
        end
    endtask

    task automatic test_control_flow();
        logic [2:0] f3s [6];
        f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        load_reg(1, 32'hffff_fffd);
        load_reg(2, 32'd5);
        foreach (f3s[k]) begin
            run_instr(enc_b(13'd12, 2, 1, f3s[k]));
            run_instr(enc_b(13'd12, 1, 2, f3s[k]));
            run_instr(enc_b(13'd8, 1, 1, f3s[k]));
        end
        run_instr(enc_j(21'd20, 21));
        load_reg(8, 32'h0000_0a01);
        run_instr(enc_i(12'd4, 8, 3'd0, 22, `RV_OP_JALR));    // Target odd before clearing
        run_instr(enc_i(12'hffc, 8, 3'd0, 8, `RV_OP_JALR));   // rd equals rs1
    endtask

    task automatic test_x0_unknown();
        run_instr(enc_i(12'd123, 0, 3'd0, 0, `RV_OP_IMM));
        run_instr(enc_r(7'b0, 2, 1, 3'd0, 0, `RV_OP_OP));
        run_instr(enc_r(7'b0, 0, 0, 3'd6, 23, `RV_OP_OP));
        run_instr(32'hffff_ffff);
        run_instr(32'h0000_157f);
        run_instr(enc_i(12'd0, 0, 3'd0, 24, `RV_OP_IMM));
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        seed      = 37113;
        rst_n     = 1'b0;
        instr     = 32'h0000_0013;
        m_pc      = `RV_RESET_PC;
        for (int i = 0; i < 1024; i++) begin
            prog[i] = 32'h0000_0013;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i]  = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
            m_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end

        test_reset_nop();
        test_int_alu();
        test_mul_div();
        test_load_store();
        test_control_flow();
        test_x0_unknown();

        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+common
common/common.sv
hw/control_unit.sv
hw/imm_gen.sv
hw/reg_file.sv
hw/alu.sv
hw/mem_stage.sv
hw/pc_unit.sv
hw/rv_core.sv
tests/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - common
    files:
      - common/common.sv
      - hw/control_unit.sv
      - hw/imm_gen.sv
      - hw/reg_file.sv
      - hw/alu.sv
      - hw/mem_stage.sv
      - hw/pc_unit.sv
      - hw/rv_core.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - tests/tb_rv_core.sv
